// ==== include/fpu_params.svh ====
`ifndef FPU_PARAMS_SVH
`define FPU_PARAMS_SVH

// wishbone byte address width
`define FPU_ADR_W 5

// register offsets
`define FPU_REG_OP1    5'h00
`define FPU_REG_OP2    5'h04
`define FPU_REG_CMD    5'h08
`define FPU_REG_RESULT 5'h0C
`define FPU_REG_STATUS 5'h10

// ieee single format
`define FP_EXP_BIAS  127
`define FP_SIGN_MASK 32'h8000_0000

`endif

// ==== hw/fpu_pkg.sv ====
package fpu_pkg;

    // ieee single precision layout
    typedef struct packed {
        logic        sign;
        logic [7:0]  exp;
        logic [22:0] frac;
    } fp_fields_t;

    // same word seen as a float or as a signed integer
    typedef union packed {
        fp_fields_t         f;
        logic signed [31:0] i;
    } fp_word_u;

    // command register encoding
    typedef enum logic [3:0] {
        FP_ADD     = 4'd0,
        FP_SUB     = 4'd1,
        FP_MUL     = 4'd2,
        FP_DIV     = 4'd3,
        FP_EQ      = 4'd4,
        FP_SLT     = 4'd5,
        FP_NEG     = 4'd6,
        FP_ABS     = 4'd7,
        FP_FCVT_WS = 4'd8,
        FP_FCVT_SW = 4'd9
    } fp_op_e;

    // answer of one execution unit
    typedef struct packed {
        logic [31:0] result;
        logic        cmp;
    } fp_unit_out_t;

endpackage

// ==== hw/wb_pkg.sv ====
`include "fpu_params.svh"

package wb_pkg;

    // master to slave
    typedef struct packed {
        logic                  cyc;
        logic                  stb;
        logic                  we;
        logic [`FPU_ADR_W-1:0] adr;
        logic [31:0]           dat;
        logic [3:0]            sel;
    } wb_req_t;

    // slave to master
    typedef struct packed {
        logic        ack;
        logic [31:0] dat;
    } wb_rsp_t;

endpackage

// ==== hw/fp_arith_unit.sv ====
`timescale 1ns/1ps
`include "fpu_params.svh"

module fp_arith_unit import fpu_pkg::*; (
    input  fp_word_u     op1,
    input  fp_word_u     op2,
    input  fp_op_e       op,
    output fp_unit_out_t res
);

    fp_fields_t        a;
    fp_fields_t        b;
    logic              sign_b;
    logic [23:0]       sig_a;
    logic [23:0]       sig_b;

    logic              a_big;
    logic              big_sign;
    logic              small_sign;
    logic [7:0]        exp_diff;
    logic [27:0]       ext_big;
    logic [27:0]       ext_small;
    logic [27:0]       ext_aligned;
    logic [27:0]       sum;
    logic [27:0]       norm;
    logic              sum_sign;
    logic signed [9:0] sum_exp;
    logic [4:0]        lead;
    logic [4:0]        lz;
    logic [31:0]       addsub_word;

    logic [47:0]       product;
    logic signed [9:0] mul_exp;
    logic [31:0]       mul_word;

    logic [47:0]       divisor;
    logic [47:0]       quotient;
    logic signed [9:0] div_exp;
    logic [22:0]       div_frac;
    logic [31:0]       div_word;

    function automatic logic [7:0] clamp_exp(input logic signed [9:0] e);
        logic [7:0] e_out;
        if (e <= 10'sd0) begin
            e_out = 8'd0;
        end else if (e >= 10'sd255) begin
            e_out = 8'd255;
        end else begin
            e_out = e[7:0];
        end
        return e_out;
    endfunction

    function automatic logic [31:0] round_pack(
        input logic              sgn,
        input logic signed [9:0] exp_in,
        input logic [23:0]       mant,
        input logic              guard,
        input logic              rnd,
        input logic              sticky
    );
        logic [24:0]       mant_r;
        logic signed [9:0] exp_r;
        // round to nearest with ties to the even mantissa
        mant_r = {1'b0, mant} + {24'd0, guard & (rnd | sticky | mant[0])};
        exp_r  = exp_in;
        if (mant_r[24]) begin
            mant_r = mant_r >> 1;
            exp_r  = exp_r + 10'sd1;
        end
        return {sgn, clamp_exp(exp_r), mant_r[22:0]};
    endfunction

    assign a      = op1.f;
    assign b      = op2.f;
    assign sign_b = b.sign ^ (op == FP_SUB);

    // zero exponent flushes the operand to zero
    assign sig_a = (a.exp == 8'd0) ? 24'd0 : {1'b1, a.frac};
    assign sig_b = (b.exp == 8'd0) ? 24'd0 : {1'b1, b.frac};

    // ==========================================================
    // add and subtract
    // ==========================================================
    always_comb begin
        a_big      = (a.exp > b.exp);
        exp_diff   = a_big ? (a.exp - b.exp) : (b.exp - a.exp);
        ext_big    = a_big ? {1'b0, sig_a, 3'b000} : {1'b0, sig_b, 3'b000};
        ext_small  = a_big ? {1'b0, sig_b, 3'b000} : {1'b0, sig_a, 3'b000};
        big_sign   = a_big ? a.sign : sign_b;
        small_sign = a_big ? sign_b : a.sign;
        sum_exp    = $signed({2'b00, (a_big ? a.exp : b.exp)});

        // anything shifted out folds into the sticky bit
        ext_aligned    = ext_small >> exp_diff;
        ext_aligned[0] = ext_aligned[0] | (|(ext_small & ~(28'hFFF_FFFF << exp_diff)));

        if (big_sign == small_sign) begin
            sum      = ext_big + ext_aligned;
            sum_sign = big_sign;
        end else if (ext_big >= ext_aligned) begin
            sum      = ext_big - ext_aligned;
            sum_sign = big_sign;
        end else begin
            sum      = ext_aligned - ext_big;
            sum_sign = small_sign;
        end

        lead = 5'd0;
        for (int i = 0; i < 27; i++) begin
            if (sum[i]) begin
                lead = i[4:0];
            end
        end
        lz = 5'd26 - lead;

        if (sum[27]) begin
            norm    = {1'b0, sum[27:2], sum[1] | sum[0]};
            sum_exp = sum_exp + 10'sd1;
        end else begin
            norm    = sum << lz;
            sum_exp = sum_exp - $signed({5'd0, lz});
        end

        if (sum == 28'd0) begin
            addsub_word = 32'd0;
        end else begin
            addsub_word = round_pack(sum_sign, sum_exp, norm[26:3], norm[2], norm[1], norm[0]);
        end
    end

    // ==========================================================
    // multiply
    // ==========================================================
    always_comb begin
        product = sig_a * sig_b;
        mul_exp = $signed({2'b00, a.exp}) + $signed({2'b00, b.exp})
                - $signed(10'(`FP_EXP_BIAS));
        if (sig_a == 24'd0 || sig_b == 24'd0) begin
            mul_word = 32'd0;
        end else if (product[47]) begin
            mul_word = round_pack(a.sign ^ b.sign, mul_exp + 10'sd1, product[47:24],
                                  product[23], product[22], |product[21:0]);
        end else begin
            mul_word = round_pack(a.sign ^ b.sign, mul_exp, product[46:23],
                                  product[22], product[21], |product[20:0]);
        end
    end

    // ==========================================================
    // divide
    // ==========================================================
    always_comb begin
        divisor  = (sig_b == 24'd0) ? 48'd1 : {24'd0, sig_b};
        quotient = {sig_a, 24'd0} / divisor;
        div_exp  = $signed({2'b00, a.exp}) - $signed({2'b00, b.exp})
                 + $signed(10'(`FP_EXP_BIAS));
        // significand ratio lies in (0.5, 2), so the top bit is 24 or 23
        if (quotient[24]) begin
            div_frac = quotient[23:1];
        end else begin
            div_exp  = div_exp - 10'sd1;
            div_frac = quotient[22:0];
        end

        if (sig_a == 24'd0) begin
            div_word = 32'd0;
        end else if (sig_b == 24'd0) begin
            div_word = {a.sign ^ b.sign, 8'hFF, 23'd0};
        end else begin
            div_word = {a.sign ^ b.sign, clamp_exp(div_exp), div_frac};
        end
    end

    always_comb begin
        res.cmp = 1'b0;
        case (op)
            FP_ADD, FP_SUB: res.result = addsub_word;
            FP_MUL:         res.result = mul_word;
            FP_DIV:         res.result = div_word;
            default:        res.result = 32'd0;
        endcase
    end

endmodule

// ==== hw/fp_cmp_conv_unit.sv ====
`timescale 1ns/1ps
`include "fpu_params.svh"

module fp_cmp_conv_unit import fpu_pkg::*; (
    input  fp_word_u     op1,
    input  fp_word_u     op2,
    input  fp_op_e       op,
    output fp_unit_out_t res
);

    fp_fields_t        a;
    fp_fields_t        b;
    logic              eq;
    logic              mag_lt;
    logic              mag_gt;
    logic              slt;

    logic signed [9:0] unb_exp;
    logic [31:0]       ws_mag;
    logic [31:0]       ws_word;

    logic [31:0]       sw_mag;
    logic [4:0]        sw_lead;
    logic [31:0]       sw_sig;
    logic [31:0]       sw_word;

    assign a  = op1.f;
    assign b  = op2.f;
    assign eq = (op1.i == op2.i);

    // exponent and fraction compare as one magnitude
    assign mag_lt = {a.exp, a.frac} < {b.exp, b.frac};
    assign mag_gt = {a.exp, a.frac} > {b.exp, b.frac};
    assign slt    = (a.sign != b.sign) ? a.sign : (a.sign ? mag_gt : mag_lt);

    // float to int truncates toward zero
    always_comb begin
        unb_exp = $signed({2'b00, a.exp}) - $signed(10'(`FP_EXP_BIAS));
        ws_mag  = 32'd0;
        if (a.exp == 8'hFF || unb_exp >= 10'sd31) begin
            ws_word = a.sign ? 32'h8000_0000 : 32'h7FFF_FFFF;
        end else if (a.exp == 8'd0 || unb_exp < 10'sd0) begin
            ws_word = 32'd0;
        end else begin
            if (unb_exp >= 10'sd23) begin
                ws_mag = {8'd0, 1'b1, a.frac} << (unb_exp[4:0] - 5'd23);
            end else begin
                ws_mag = {8'd0, 1'b1, a.frac} >> (5'd23 - unb_exp[4:0]);
            end
            ws_word = a.sign ? -ws_mag : ws_mag;
        end
    end

    // int to float takes its exponent from the leading one
    always_comb begin
        sw_mag  = op1.i[31] ? -op1.i : op1.i;
        sw_lead = 5'd0;
        for (int i = 0; i < 32; i++) begin
            if (sw_mag[i]) begin
                sw_lead = i[4:0];
            end
        end
        if (sw_lead >= 5'd23) begin
            sw_sig = sw_mag >> (sw_lead - 5'd23);
        end else begin
            sw_sig = sw_mag << (5'd23 - sw_lead);
        end
        if (op1.i == 32'sd0) begin
            sw_word = 32'd0;
        end else begin
            sw_word = {op1.i[31], 8'(`FP_EXP_BIAS) + {3'd0, sw_lead}, sw_sig[22:0]};
        end
    end

    always_comb begin
        res = '0;
        case (op)
            FP_EQ: begin
                res.result = {31'd0, eq};
                res.cmp    = eq;
            end
            FP_SLT:     res.cmp    = slt;
            FP_NEG:     res.result = op1.i ^ `FP_SIGN_MASK;
            FP_ABS:     res.result = op1.i & ~`FP_SIGN_MASK;
            FP_FCVT_WS: res.result = ws_word;
            FP_FCVT_SW: res.result = sw_word;
            default:    res = '0;
        endcase
    end

endmodule

// ==== hw/fpu_wb_slave.sv ====
`timescale 1ns/1ps
`include "fpu_params.svh"

module fpu_wb_slave import fpu_pkg::*, wb_pkg::*; (
    input  logic         clk,
    input  logic         arst_n,
    input  wb_req_t      wb_req,
    output wb_rsp_t      wb_rsp,
    output fp_word_u     op1,
    output fp_word_u     op2,
    output fp_op_e       op,
    input  fp_unit_out_t arith_out,
    input  fp_unit_out_t cc_out
);

    logic         ack_q;
    logic         req_valid;
    logic         wr_en;
    logic [3:0]   cmd_q;
    logic [31:0]  result_q;
    logic         cmp_q;
    fp_unit_out_t unit_sel;
    logic [31:0]  rd_data;

    function automatic logic [31:0] byte_merge(
        input logic [31:0] old_val,
        input logic [31:0] new_val,
        input logic [3:0]  byte_en
    );
        logic [31:0] merged;
        merged = old_val;
        for (int i = 0; i < 4; i++) begin
            if (byte_en[i]) begin
                merged[i*8 +: 8] = new_val[i*8 +: 8];
            end
        end
        return merged;
    endfunction

    // ==========================================================
    // wishbone classic handshake
    // ==========================================================
    // one idle clock after each ack
    assign req_valid = wb_req.cyc & wb_req.stb & ~ack_q;
    assign wr_en     = req_valid & wb_req.we;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            ack_q <= 1'b0;
        end else begin
            ack_q <= req_valid;
        end
    end

    // ==========================================================
    // operand and command registers
    // ==========================================================
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            op1   <= '0;
            op2   <= '0;
            cmd_q <= 4'd0;
        end else if (wr_en) begin
            case (wb_req.adr)
                `FPU_REG_OP1: op1 <= byte_merge(op1, wb_req.dat, wb_req.sel);
                `FPU_REG_OP2: op2 <= byte_merge(op2, wb_req.dat, wb_req.sel);
                `FPU_REG_CMD: begin
                    if (wb_req.sel[0]) begin
                        cmd_q <= wb_req.dat[3:0];
                    end
                end
                default: ;
            endcase
        end
    end

    assign op = fp_op_e'(cmd_q);

    // pick the unit that owns the current command
    always_comb begin
        case (op)
            FP_ADD, FP_SUB, FP_MUL, FP_DIV: unit_sel = arith_out;
            FP_EQ, FP_SLT, FP_NEG, FP_ABS, FP_FCVT_WS, FP_FCVT_SW: unit_sel = cc_out;
            default: unit_sel = '0;
        endcase
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            result_q <= 32'd0;
            cmp_q    <= 1'b0;
        end else begin
            result_q <= unit_sel.result;
            cmp_q    <= unit_sel.cmp;
        end
    end

    // held address keeps read data stable while ack is high
    always_comb begin
        case (wb_req.adr)
            `FPU_REG_OP1:    rd_data = op1;
            `FPU_REG_OP2:    rd_data = op2;
            `FPU_REG_CMD:    rd_data = {28'd0, cmd_q};
            `FPU_REG_RESULT: rd_data = result_q;
            `FPU_REG_STATUS: rd_data = {31'd0, cmp_q};
            default:         rd_data = 32'd0;
        endcase
    end

    assign wb_rsp.ack = ack_q;
    assign wb_rsp.dat = rd_data;

endmodule

// ==== hw/fpu_wb_top.sv ====
`timescale 1ns/1ps

module fpu_wb_top import fpu_pkg::*, wb_pkg::*; (
    input  logic    clk,
    input  logic    arst_n,
    input  wb_req_t wb_req,
    output wb_rsp_t wb_rsp
);

    fp_word_u     op1;
    fp_word_u     op2;
    fp_op_e       op;
    fp_unit_out_t arith_out;
    fp_unit_out_t cc_out;

    fpu_wb_slave u_fpu_wb_slave (
        .clk       (clk),
        .arst_n    (arst_n),
        .wb_req    (wb_req),
        .wb_rsp    (wb_rsp),
        .op1       (op1),
        .op2       (op2),
        .op        (op),
        .arith_out (arith_out),
        .cc_out    (cc_out)
    );

    fp_arith_unit u_fp_arith_unit (
        .op1 (op1),
        .op2 (op2),
        .op  (op),
        .res (arith_out)
    );

    fp_cmp_conv_unit u_fp_cmp_conv_unit (
        .op1 (op1),
        .op2 (op2),
        .op  (op),
        .res (cc_out)
    );

endmodule

// ==== verif/tb_fpu_wb.sv ====
`timescale 1ns/1ps
`include "fpu_params.svh"

module tb_fpu_wb import fpu_pkg::*, wb_pkg::*;;

    logic        clk;
    logic        arst_n;
    wb_req_t     wb_req;
    wb_rsp_t     wb_rsp;
    int          error_count;
    logic [31:0] lcg_state;

    fpu_wb_top u_fpu_wb_top (
        .clk    (clk),
        .arst_n (arst_n),
        .wb_req (wb_req),
        .wb_rsp (wb_rsp)
    );

    always #2 clk = ~clk;

    function logic [31:0] lcg_next();
        lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
        return lcg_state;
    endfunction

    // ============================================================
    // wishbone classic master
    // ============================================================
    task automatic bus_cycle(input logic we, input logic [`FPU_ADR_W-1:0] adr,
                             input logic [31:0] dat, input logic [3:0] sel,
                             output logic [31:0] rdata);
        int wait_cnt;
        wait_cnt = 0;
        rdata    = 32'd0;
        @(posedge clk);
        #0.5;
        wb_req.cyc = 1'b1;
        wb_req.stb = 1'b1;
        wb_req.we  = we;
        wb_req.adr = adr;
        wb_req.dat = dat;
        wb_req.sel = sel;
        // ack is sampled on the falling edge where it is stable
        @(negedge clk);
        while (!wb_rsp.ack && wait_cnt < 20) begin
            @(negedge clk);
            wait_cnt++;
        end
        if (!wb_rsp.ack) begin
            $display("bus cycle to address %h got no ack within 20 cycles", adr);
            error_count++;
        end else begin
            rdata = wb_rsp.dat;
        end
        @(posedge clk);
        #0.5;
        wb_req.cyc = 1'b0;
        wb_req.stb = 1'b0;
        wb_req.we  = 1'b0;
    endtask

    task automatic wb_write(input logic [`FPU_ADR_W-1:0] adr, input logic [31:0] dat,
                            input logic [3:0] sel);
        logic [31:0] unused_rd;
        bus_cycle(1'b1, adr, dat, sel, unused_rd);
    endtask

    task automatic wb_read(input logic [`FPU_ADR_W-1:0] adr, output logic [31:0] dat);
        bus_cycle(1'b0, adr, 32'd0, 4'hF, dat);
    endtask

    task automatic check_reg(input logic [`FPU_ADR_W-1:0] adr, input string name,
                             input logic [31:0] expected);
        logic [31:0] actual;
        wb_read(adr, actual);
        if (actual !== expected) begin
            $display("** Error at %0t: %s expected %h, got %h", $time, name, expected, actual);
            error_count++;
        end
    endtask

    task automatic run_op(input logic [31:0] a, input logic [31:0] b, input logic [3:0] cmd);
        wb_write(`FPU_REG_OP1, a, 4'hF);
        wb_write(`FPU_REG_OP2, b, 4'hF);
        wb_write(`FPU_REG_CMD, {28'd0, cmd}, 4'hF);
    endtask

    // ============================================================
    // directed tests
    // ============================================================
    task automatic test_register_access();
        check_reg(`FPU_REG_RESULT, "RESULT", 32'h0000_0000);
        check_reg(`FPU_REG_STATUS, "STATUS", 32'h0000_0000);
        // read-only register keeps the zero answer
        wb_write(`FPU_REG_RESULT, 32'hDEAD_BEEF, 4'hF);
        check_reg(`FPU_REG_RESULT, "RESULT", 32'h0000_0000);
        wb_write(`FPU_REG_OP1, 32'h1234_5678, 4'hF);
        check_reg(`FPU_REG_OP1, "OP1", 32'h1234_5678);
        wb_write(`FPU_REG_OP2, 32'hAABB_CCDD, 4'hF);
        wb_write(`FPU_REG_OP2, 32'h1122_3344, 4'b0101);
        check_reg(`FPU_REG_OP2, "OP2", 32'hAA22_CC44);
        wb_write(`FPU_REG_CMD, 32'h0000_0009, 4'hF);
        check_reg(`FPU_REG_CMD, "CMD", 32'h0000_0009);
        check_reg(5'h14, "unmapped 0x14", 32'h0000_0000);
        check_reg(5'h1C, "unmapped 0x1C", 32'h0000_0000);
    endtask

    task automatic test_add_sub();
        run_op(32'h3FC0_0000, 32'h4010_0000, FP_ADD);
        check_reg(`FPU_REG_RESULT, "RESULT add", 32'h4070_0000);
        run_op(32'h40A0_0000, 32'h40F0_0000, FP_SUB);
        check_reg(`FPU_REG_RESULT, "RESULT sub", 32'hC020_0000);
        run_op(32'h4070_0000, 32'h4070_0000, FP_SUB);
        check_reg(`FPU_REG_RESULT, "RESULT x-x", 32'h0000_0000);
    endtask

    task automatic test_mul_div();
        run_op(32'h4040_0000, 32'h3F00_0000, FP_MUL);
        check_reg(`FPU_REG_RESULT, "RESULT mul", 32'h3FC0_0000);
        run_op(32'hC000_0000, 32'h4080_0000, FP_MUL);
        check_reg(`FPU_REG_RESULT, "RESULT mul neg", 32'hC100_0000);
        run_op(32'h40C0_0000, 32'h4080_0000, FP_DIV);
        check_reg(`FPU_REG_RESULT, "RESULT div", 32'h3FC0_0000);
        run_op(32'h3F80_0000, 32'h4000_0000, FP_DIV);
        check_reg(`FPU_REG_RESULT, "RESULT div half", 32'h3F00_0000);
        check_reg(`FPU_REG_STATUS, "STATUS div", 32'h0000_0000);
    endtask

    task automatic test_compare_sign();
        run_op(32'h4070_0000, 32'h4070_0000, FP_EQ);
        check_reg(`FPU_REG_RESULT, "RESULT eq", 32'h0000_0001);
        check_reg(`FPU_REG_STATUS, "STATUS eq", 32'h0000_0001);
        run_op(32'h4070_0000, 32'h4070_0001, FP_EQ);
        check_reg(`FPU_REG_RESULT, "RESULT ne", 32'h0000_0000);
        check_reg(`FPU_REG_STATUS, "STATUS ne", 32'h0000_0000);
        // mixed signs, then equal exponents of both signs
        run_op(32'hBF80_0000, 32'h4000_0000, FP_SLT);
        check_reg(`FPU_REG_STATUS, "STATUS slt -1<2", 32'h0000_0001);
        check_reg(`FPU_REG_RESULT, "RESULT slt", 32'h0000_0000);
        run_op(32'h4000_0000, 32'hBF80_0000, FP_SLT);
        check_reg(`FPU_REG_STATUS, "STATUS slt 2<-1", 32'h0000_0000);
        run_op(32'h3FC0_0000, 32'h3FE0_0000, FP_SLT);
        check_reg(`FPU_REG_STATUS, "STATUS slt 1.5<1.75", 32'h0000_0001);
        run_op(32'h3FE0_0000, 32'h3FC0_0000, FP_SLT);
        check_reg(`FPU_REG_STATUS, "STATUS slt 1.75<1.5", 32'h0000_0000);
        run_op(32'hBFE0_0000, 32'hBFC0_0000, FP_SLT);
        check_reg(`FPU_REG_STATUS, "STATUS slt -1.75<-1.5", 32'h0000_0001);
        run_op(32'h3FC0_0000, 32'h0, FP_NEG);
        check_reg(`FPU_REG_RESULT, "RESULT neg pos", 32'hBFC0_0000);
        run_op(32'hC020_0000, 32'h0, FP_NEG);
        check_reg(`FPU_REG_RESULT, "RESULT neg neg", 32'h4020_0000);
        run_op(32'hC020_0000, 32'h0, FP_ABS);
        check_reg(`FPU_REG_RESULT, "RESULT abs neg", 32'h4020_0000);
        run_op(32'h3FC0_0000, 32'h0, FP_ABS);
        check_reg(`FPU_REG_RESULT, "RESULT abs pos", 32'h3FC0_0000);
    endtask

    task automatic test_conversions();
        logic [31:0] n;
        logic [31:0] as_float;
        run_op(32'h42C9_8000, 32'h0, FP_FCVT_WS);
        check_reg(`FPU_REG_RESULT, "RESULT ws 100.75", 32'd100);
        run_op(32'hC0E0_0000, 32'h0, FP_FCVT_WS);
        check_reg(`FPU_REG_RESULT, "RESULT ws -7", 32'hFFFF_FFF9);
        run_op(32'h4F00_0000, 32'h0, FP_FCVT_WS);
        check_reg(`FPU_REG_RESULT, "RESULT ws 2^31", 32'h7FFF_FFFF);
        run_op(32'h3F00_0000, 32'h0, FP_FCVT_WS);
        check_reg(`FPU_REG_RESULT, "RESULT ws 0.5", 32'h0000_0000);
        run_op(32'd1000, 32'h0, FP_FCVT_SW);
        check_reg(`FPU_REG_RESULT, "RESULT sw 1000", 32'h447A_0000);
        // int to float and back is exact below 2^24
        for (int k = 0; k < 20; k++) begin
            n = lcg_next() >> 8;
            if (lcg_state[7]) begin
                n = 32'd0 - n;
            end
            run_op(n, 32'h0, FP_FCVT_SW);
            wb_read(`FPU_REG_RESULT, as_float);
            run_op(as_float, 32'h0, FP_FCVT_WS);
            check_reg(`FPU_REG_RESULT, "RESULT round trip", n);
        end
    endtask

    task automatic test_undefined_cmd();
        run_op(32'h4070_0000, 32'h4070_0000, FP_EQ);
        run_op(32'h3FC0_0000, 32'h4010_0000, 4'd15);
        check_reg(`FPU_REG_RESULT, "RESULT undef", 32'h0000_0000);
        check_reg(`FPU_REG_STATUS, "STATUS undef", 32'h0000_0000);
        check_reg(`FPU_REG_OP1, "OP1 undef", 32'h3FC0_0000);
        check_reg(`FPU_REG_OP2, "OP2 undef", 32'h4010_0000);
        check_reg(`FPU_REG_CMD, "CMD undef", 32'h0000_000F);
    endtask

    initial begin
        clk         = 1'b0;
        arst_n      = 1'b0;
        wb_req      = '0;
        error_count = 0;
        lcg_state   = 32'd49280;
        repeat (16) @(posedge clk);
        #0.5;
        arst_n = 1'b1;

        test_register_access();
        test_add_sub();
        test_mul_div();
        test_compare_sign();
        test_conversions();
        test_undefined_cmd();

        $display("tests finished with %0d errors", error_count);
        if (error_count == 0) begin
            $display("All tests passed");
        end else begin
            $display("Some tests failed");
        end
        $finish;
    end

endmodule

// ==== src.f ====
+incdir+include
hw/fpu_pkg.sv
hw/wb_pkg.sv
hw/fp_arith_unit.sv
hw/fp_cmp_conv_unit.sv
hw/fpu_wb_slave.sv
hw/fpu_wb_top.sv
verif/tb_fpu_wb.sv

// ==== run.sh ====
#!/bin/sh
# build and run the FPU testbench with Verilator

LOG=sim.log
OBJ=obj_dir

verilator --binary --top-module tb_fpu_wb -f src.f --Mdir "$OBJ" -o tb_fpu_wb
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

"./$OBJ/tb_fpu_wb" > "$LOG" 2>&1
sim_status=$?
cat "$LOG"
if [ $sim_status -ne 0 ]; then
    echo "simulation exited with status $sim_status"
    exit 1
fi

if grep -q "Some tests failed" "$LOG"; then
    exit 1
fi
if [ ! -s "$LOG" ]; then
    echo "simulation log is empty"
    exit 1
fi
exit 0
